// ==== verilog/tim_pkg.sv ====
package tim_pkg;

  // bus geometry
  localparam int addr_bits = 32;
  localparam int data_bits = 32;
  localparam int byte_bits = 8;
  localparam int strb_bits = data_bits / byte_bits;
  localparam int offset_bits = $clog2(strb_bits);  // byte offset inside a word

  // tim geometry
  localparam int tim_depth = 256;  // words per bank
  localparam int tim_width = 4;  // number of banks
  localparam int row_bits = $clog2(tim_depth);
  localparam int bank_bits = $clog2(tim_width);

  // byte address on the bus
  typedef logic [addr_bits-1:0] addr_t;

  // data word
  typedef logic [data_bits-1:0] data_t;

  // byte write strobes, zero means read
  typedef logic [strb_bits-1:0] strb_t;

  // word index inside a bank
  typedef logic [row_bits-1:0] row_t;

  // bank select
  typedef logic [bank_bits-1:0] bank_t;

  // master whose response is in flight
  typedef enum logic [1:0] {
    owner_none,
    owner_a,
    owner_b
  } owner_t;

endpackage

// ==== verilog/tim_bank.sv ====
`timescale 1ns/100ps

module tim_bank (
  input  logic           clock,
  input  logic           en,
  input  tim_pkg::row_t  row,
  input  tim_pkg::strb_t strb,
  input  tim_pkg::data_t wdata,
  output tim_pkg::data_t rdata
);

  import tim_pkg::*;

  data_t mem [tim_depth] = '{default: '0};  // starts cleared

  always_ff @(posedge clock) begin
    if (en) begin
      rdata <= mem[row];  // read-first, old word even on a write
      for (int lane = 0; lane < strb_bits; lane++) begin
        if (strb[lane]) begin
          mem[row][lane*byte_bits +: byte_bits] <= wdata[lane*byte_bits +: byte_bits];
        end
      end
    end else begin
      rdata <= '0;  // idle bank drives zero
    end
  end

endmodule

// ==== verilog/tim_ctrl.sv ====
`timescale 1ns/100ps

module tim_ctrl (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          m_valid,
  input  tim_pkg::addr_t                m_addr,
  input  tim_pkg::data_t                m_wdata,
  input  tim_pkg::strb_t                m_strb,
  output logic                          m_ready,
  output tim_pkg::data_t                m_rdata,
  output logic [tim_pkg::tim_width-1:0] bank_en,
  output tim_pkg::row_t                 bank_row,
  output tim_pkg::strb_t                bank_strb,
  output tim_pkg::data_t                bank_wdata,
  input  tim_pkg::data_t                bank_rdata [tim_pkg::tim_width]
);

  import tim_pkg::*;

  bank_t sel_bank;
  row_t  sel_row;
  logic  resp_valid;  // request accepted last cycle
  bank_t resp_bank;  // bank that holds its read data

  // low word bits pick the bank, so consecutive words interleave
  assign sel_bank = m_addr[offset_bits +: bank_bits];
  assign sel_row  = m_addr[offset_bits+bank_bits +: row_bits];  // upper bits wrap

  always_comb begin
    bank_en           = '0;
    bank_en[sel_bank] = m_valid;  // only the addressed bank acts
  end

  // shared by all banks
  assign bank_row   = sel_row;
  assign bank_strb  = m_strb;
  assign bank_wdata = m_wdata;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      resp_valid <= 1'b0;
      resp_bank  <= '0;
    end else begin
      resp_valid <= m_valid;
      if (m_valid) begin
        resp_bank <= sel_bank;
      end
    end
  end

  assign m_ready = resp_valid;
  assign m_rdata = bank_rdata[resp_bank];  // idle banks output zero anyway

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter (
  input  logic           clock,
  input  logic           reset,
  input  logic           a_valid,
  input  tim_pkg::addr_t a_addr,
  input  tim_pkg::data_t a_wdata,
  input  tim_pkg::strb_t a_strb,
  output logic           a_ready,
  output tim_pkg::data_t a_rdata,
  input  logic           b_valid,
  input  tim_pkg::addr_t b_addr,
  input  tim_pkg::data_t b_wdata,
  input  tim_pkg::strb_t b_strb,
  output logic           b_ready,
  output tim_pkg::data_t b_rdata,
  output logic           m_valid,
  output tim_pkg::addr_t m_addr,
  output tim_pkg::data_t m_wdata,
  output tim_pkg::strb_t m_strb,
  input  logic           m_ready,
  input  tim_pkg::data_t m_rdata
);

  import tim_pkg::*;

  owner_t owner;  // granted last cycle, response due now
  owner_t owner_next;
  logic   last_b;  // b won the latest grant
  logic   a_elig;
  logic   b_elig;
  logic   grant_a;
  logic   grant_b;

  // a master whose answer arrives this cycle still shows its old request
  assign a_elig = a_valid && (owner != owner_a);
  assign b_elig = b_valid && (owner != owner_b);

  // round robin, the side not granted last takes a tie
  assign grant_a = a_elig && (!b_elig || last_b);
  assign grant_b = b_elig && (!a_elig || !last_b);

  always_comb begin
    m_valid    = grant_a || grant_b;
    m_addr     = grant_b ? b_addr : a_addr;
    m_wdata    = grant_b ? b_wdata : a_wdata;
    m_strb     = grant_b ? b_strb : a_strb;
    owner_next = owner_none;
    if (grant_a) begin
      owner_next = owner_a;
    end else if (grant_b) begin
      owner_next = owner_b;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      owner  <= owner_none;
      last_b <= 1'b0;
    end else begin
      owner <= owner_next;
      if (m_valid) begin
        last_b <= grant_b;
      end
    end
  end

  // response goes back to the owner only
  assign a_ready = m_ready && (owner == owner_a);
  assign a_rdata = (owner == owner_a) ? m_rdata : '0;
  assign b_ready = m_ready && (owner == owner_b);
  assign b_rdata = (owner == owner_b) ? m_rdata : '0;

endmodule

// ==== verilog/tim_top.sv ====
`timescale 1ns/100ps

module tim_top (
  input  logic           clock,
  input  logic           reset,
  input  logic           a_valid,
  input  tim_pkg::addr_t a_addr,
  input  tim_pkg::data_t a_wdata,
  input  tim_pkg::strb_t a_strb,
  output logic           a_ready,
  output tim_pkg::data_t a_rdata,
  input  logic           b_valid,
  input  tim_pkg::addr_t b_addr,
  input  tim_pkg::data_t b_wdata,
  input  tim_pkg::strb_t b_strb,
  output logic           b_ready,
  output tim_pkg::data_t b_rdata
);

  import tim_pkg::*;

  // merged bus
  logic  m_valid;
  addr_t m_addr;
  data_t m_wdata;
  strb_t m_strb;
  logic  m_ready;
  data_t m_rdata;

  // bank side
  logic [tim_width-1:0] bank_en;
  row_t                 bank_row;
  strb_t                bank_strb;
  data_t                bank_wdata;
  data_t                bank_rdata [tim_width];

  mem_arbiter arb0 (
    .clock   (clock),
    .reset   (reset),
    .a_valid (a_valid),
    .a_addr  (a_addr),
    .a_wdata (a_wdata),
    .a_strb  (a_strb),
    .a_ready (a_ready),
    .a_rdata (a_rdata),
    .b_valid (b_valid),
    .b_addr  (b_addr),
    .b_wdata (b_wdata),
    .b_strb  (b_strb),
    .b_ready (b_ready),
    .b_rdata (b_rdata),
    .m_valid (m_valid),
    .m_addr  (m_addr),
    .m_wdata (m_wdata),
    .m_strb  (m_strb),
    .m_ready (m_ready),
    .m_rdata (m_rdata)
  );

  tim_ctrl ctrl0 (
    .clock      (clock),
    .reset      (reset),
    .m_valid    (m_valid),
    .m_addr     (m_addr),
    .m_wdata    (m_wdata),
    .m_strb     (m_strb),
    .m_ready    (m_ready),
    .m_rdata    (m_rdata),
    .bank_en    (bank_en),
    .bank_row   (bank_row),
    .bank_strb  (bank_strb),
    .bank_wdata (bank_wdata),
    .bank_rdata (bank_rdata)
  );

  for (genvar i = 0; i < tim_width; i++) begin : g_bank
    tim_bank bank (
      .clock (clock),
      .en    (bank_en[i]),
      .row   (bank_row),
      .strb  (bank_strb),
      .wdata (bank_wdata),
      .rdata (bank_rdata[i])
    );
  end

endmodule

// ==== tests/tim_checker.sv ====
`timescale 1ns/100ps

module tim_checker (
  input  logic           clock,
  input  logic           reset,
  input  logic           a_valid,
  input  tim_pkg::addr_t a_addr,
  input  tim_pkg::data_t a_wdata,
  input  tim_pkg::strb_t a_strb,
  input  logic           a_ready,
  input  tim_pkg::data_t a_rdata,
  input  logic           b_valid,
  input  tim_pkg::addr_t b_addr,
  input  tim_pkg::data_t b_wdata,
  input  tim_pkg::strb_t b_strb,
  input  logic           b_ready,
  input  tim_pkg::data_t b_rdata,
  output int             mismatch_count,
  output int             protocol_count,
  output int             a_responses,
  output int             b_responses
);

  import tim_pkg::*;

  localparam int model_bits = bank_bits + row_bits;  // word address bits inside the tim
  localparam int model_words = 1 << model_bits;

  data_t      model [model_words];  // reference copy of the whole tim
  logic [1:0] pending;  // request captured and not yet answered
  addr_t      req_addr [2];
  data_t      req_wdata [2];
  strb_t      req_strb [2];
  int         req_cycle [2];
  int         cycle;
  int         mismatches = 0;
  int         protocol_errors = 0;
  int         a_seen = 0;
  int         b_seen = 0;

  assign mismatch_count = mismatches;
  assign protocol_count = protocol_errors;
  assign a_responses    = a_seen;
  assign b_responses    = b_seen;

  function automatic string port_name(input owner_t port);
    case (port)
      owner_a: return "a";
      owner_b: return "b";
      default: return "none";
    endcase
  endfunction

  // byte lanes with a set strobe take the new data
  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t result;
    result = old_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (strb[lane]) begin
        result[lane*8 +: 8] = new_word[lane*8 +: 8];
      end
    end
    return result;
  endfunction

  task automatic watch_port(input owner_t port, input logic valid, input addr_t addr,
                            input data_t wdata, input strb_t strb, input logic ready,
                            input data_t rdata);
    logic                  side;
    logic [model_bits-1:0] word;
    data_t                 expected;
    int                    latency;
    side = (port == owner_b);
    if (pending[side] && !valid) begin
      protocol_errors++;
      $display("port %s dropped valid before ready at time %0t", port_name(port), $time);
      pending[side] = 1'b0;
    end
    if (valid && !pending[side]) begin  // a new request starts here
      pending[side]   = 1'b1;
      req_addr[side]  = addr;
      req_wdata[side] = wdata;
      req_strb[side]  = strb;
      req_cycle[side] = cycle;
    end
    if (ready) begin
      if (!pending[side]) begin
        protocol_errors++;
        $display("port %s gave a ready pulse with no request open at time %0t",
                 port_name(port), $time);
      end else begin
        word     = req_addr[side][2 +: model_bits];  // bits above the tim range alias
        expected = model[word];
        latency  = cycle - req_cycle[side];
        if (rdata !== expected) begin
          mismatches++;
          $display("MISMATCH at %0t: port %s addr %h expected %h actual %h",
                   $time, port_name(port), req_addr[side], expected, rdata);
        end
        if (latency < 1 || latency > 2) begin
          protocol_errors++;
          $display("port %s was answered after %0d cycles at time %0t, allowed is 1 or 2",
                   port_name(port), latency, $time);
        end
        // responses come back in grant order, so the model follows it
        model[word]   = merge_bytes(expected, req_wdata[side], req_strb[side]);
        pending[side] = 1'b0;
        if (side) begin
          b_seen++;
        end else begin
          a_seen++;
        end
      end
    end
  endtask

  // inputs change on the rising edge, so the falling edge sees them settled
  always @(negedge clock) begin
    if (reset == 1'b0) begin
      if (a_ready || b_ready) begin
        protocol_errors++;
        $display("a ready pulse came during reset at time %0t", $time);
      end
      model   = '{default: '0};  // the tim comes up cleared
      pending = '0;
      cycle   = 0;
    end else begin
      cycle++;
      watch_port(owner_a, a_valid, a_addr, a_wdata, a_strb, a_ready, a_rdata);
      watch_port(owner_b, b_valid, b_addr, b_wdata, b_strb, b_ready, b_rdata);
    end
  end

endmodule

// ==== tests/tim_tb.sv ====
`timescale 1ns/100ps

module tim_tb;

  import tim_pkg::*;

  localparam int seed = 91654;
  localparam int req_count = 4000;  // requests per port
  localparam int timeout_cycles = 50;
  localparam int window_words = 64;  // small window so both ports hit the same words
  localparam int span_bits = offset_bits + bank_bits + row_bits;

  logic        clock = 1'b0;
  logic        reset;
  logic  [1:0] req_valid;  // index 0 is port a, 1 is port b
  addr_t [1:0] req_addr;
  data_t [1:0] req_wdata;
  strb_t [1:0] req_strb;
  logic        a_ready;
  data_t       a_rdata;
  logic        b_ready;
  data_t       b_rdata;
  int          timeouts = 0;
  int          mismatch_count;
  int          protocol_count;
  int          a_responses;
  int          b_responses;
  int          count_errors;

  always #5 clock = ~clock;

  tim_top dut0 (
    .clock   (clock),
    .reset   (reset),
    .a_valid (req_valid[0]),
    .a_addr  (req_addr[0]),
    .a_wdata (req_wdata[0]),
    .a_strb  (req_strb[0]),
    .a_ready (a_ready),
    .a_rdata (a_rdata),
    .b_valid (req_valid[1]),
    .b_addr  (req_addr[1]),
    .b_wdata (req_wdata[1]),
    .b_strb  (req_strb[1]),
    .b_ready (b_ready),
    .b_rdata (b_rdata)
  );

  tim_checker chk0 (
    .clock          (clock),
    .reset          (reset),
    .a_valid        (req_valid[0]),
    .a_addr         (req_addr[0]),
    .a_wdata        (req_wdata[0]),
    .a_strb         (req_strb[0]),
    .a_ready        (a_ready),
    .a_rdata        (a_rdata),
    .b_valid        (req_valid[1]),
    .b_addr         (req_addr[1]),
    .b_wdata        (req_wdata[1]),
    .b_strb         (req_strb[1]),
    .b_ready        (b_ready),
    .b_rdata        (b_rdata),
    .mismatch_count (mismatch_count),
    .protocol_count (protocol_count),
    .a_responses    (a_responses),
    .b_responses    (b_responses)
  );

  function automatic logic ready_of(input logic p);
    return p ? b_ready : a_ready;
  endfunction

  function automatic addr_t pick_addr();
    addr_t addr;
    if (($urandom % 8) == 0) begin
      addr = $urandom;  // anywhere in the bus range
    end else begin
      addr = (($urandom % window_words) << offset_bits) | ($urandom % strb_bits);
      if (($urandom % 4) == 0) begin
        addr = addr | ($urandom << span_bits);  // alias through the ignored upper bits
      end
    end
    return addr;
  endfunction

  task automatic drive_port(input logic p);
    int    gap;
    int    waited;
    logic  got;
    addr_t addr;
    strb_t strb;
    for (int n = 0; n < req_count; n++) begin
      gap = (($urandom % 4) == 0) ? int'($urandom % 4) : 0;
      if (gap > 0) begin
        req_valid[p] <= 1'b0;
        repeat (gap) @(posedge clock);
      end
      addr = pick_addr();
      strb = (($urandom % 2) == 0) ? '0 : strb_t'(1 + $urandom % 15);
      if (p == 1'b0 && n < 16) begin
        // opening sweep reads words 0..15 through every bank
        addr = addr_t'(n * 4);
        strb = '0;
      end
      req_valid[p] <= 1'b1;
      req_addr[p]  <= addr;
      req_wdata[p] <= $urandom;
      req_strb[p]  <= strb;
      waited = 0;
      got    = 1'b0;
      while (!got && waited < timeout_cycles) begin
        @(negedge clock);
        if (ready_of(p)) begin
          got = 1'b1;
        end else begin
          waited++;
        end
      end
      @(posedge clock);
      if (!got) begin
        timeouts++;
        $display("port %0d saw no ready within %0d cycles at time %0t",
                 p, timeout_cycles, $time);
        break;
      end
    end
    req_valid[p] <= 1'b0;
  endtask

  initial begin
    void'($urandom(seed));
    reset     <= 1'b0;
    req_valid <= '0;
    req_addr  <= '0;
    req_wdata <= '0;
    req_strb  <= '0;
    count_errors = 0;
    repeat (10) @(posedge clock);
    reset <= 1'b1;
    fork
      drive_port(1'b0);
      drive_port(1'b1);
    join
    repeat (4) @(posedge clock);
    if (a_responses != req_count || b_responses != req_count) begin
      count_errors++;
      $display("response count is wrong, port a %0d and port b %0d for %0d requests each",
               a_responses, b_responses, req_count);
    end
    $display("errors: mismatches %0d, protocol %0d, timeouts %0d, counts %0d",
             mismatch_count, protocol_count, timeouts, count_errors);
    if (mismatch_count + protocol_count + timeouts + count_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
verilog/tim_pkg.sv
verilog/tim_bank.sv
verilog/tim_ctrl.sv
verilog/mem_arbiter.sv
verilog/tim_top.sv
tests/tim_checker.sv
tests/tim_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and pass only if the output says so
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f tb.f --top-module tim_tb \
  -o tim_sim || exit 1

sim_out="$(./obj_dir/tim_sim)"
echo "$sim_out"

echo "$sim_out" | grep -q "^TEST OK$" && exit 0 || exit 1
